// File: vlog.f
design/vt_pkg.sv
design/frame_sync.sv
design/timing_gen.sv
design/line_buffer.sv
design/pixel_fetch.sv
design/video_out.sv
design/video_top.sv
sim/tb_clock.sv
sim/tb_video_top.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the video timing testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f vlog.f --top-module tb_video_top \
   -o tb_video_top_sim > build.log 2>&1
status=$?
if [ $status -ne 0 ]; then
   cat build.log
   echo "Verilator build failed with status $status"
   exit 1
fi

./obj_dir/tb_video_top_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
   echo "Simulation run exited with status $status"
   exit 1
fi

if grep -q "Simulation completed successfully" sim.log; then
   exit 0
fi
exit 1

// File: sim/tb_video_top.sv
`timescale 1ns/1ps
`default_nettype none

module tb_video_top
   import vt_pkg::*;
();

   logic                         pclk;
   logic                         reset;
   logic [COORD_W-1:0]           h_res;
   logic [COORD_W-1:0]           h_fp;
   logic [COORD_W-1:0]           h_sync;
   logic [COORD_W-1:0]           h_bp;
   logic [COORD_W-1:0]           v_res;
   logic [COORD_W-1:0]           v_fp;
   logic [COORD_W-1:0]           v_sync;
   logic [COORD_W-1:0]           v_bp;
   bpp_t                         bpp;
   logic [7:0]                   words_m1;
   logic [PAL_ENTRIES*PAL_W-1:0] palette_bus;
   logic                         dma_load;
   logic [WORD_W-1:0]            dma_data;
   logic                         flyback;
   logic                         sync_req;
   logic                         o_sync_ack;
   logic [CHAN_W-1:0]            o_r;
   logic [CHAN_W-1:0]            o_g;
   logic [CHAN_W-1:0]            o_b;
   logic                         o_hsync;
   logic                         o_vsync;
   logic                         o_de;
   logic                         o_blank;

   // Reference copies of what was loaded
   logic [PAL_W-1:0]  pal_m [PAL_ENTRIES];
   logic [WORD_W-1:0] words_m [2][4];
   int                cur_bits;

   int  errors;
   int  tests_run;
   int  tests_failed;
   bit  timed_out;
   // Geometry checks stay quiet while a resync is open
   bit  hs_busy;
   bit  pix_en;
   int  frames_checked;
   int  pixels_checked;

   tb_clock tb_clock_i (
      .o_pclk  (pclk),
      .o_reset (reset)
   );

   video_top video_top_i (
      .i_pclk              (pclk),
      .i_reset             (reset),
      .i_h_res             (h_res),
      .i_h_fp              (h_fp),
      .i_h_sync            (h_sync),
      .i_h_bp              (h_bp),
      .i_v_res             (v_res),
      .i_v_fp              (v_fp),
      .i_v_sync            (v_sync),
      .i_v_bp              (v_bp),
      .i_bpp               (bpp),
      .i_words_per_line_m1 (words_m1),
      .i_palette           (palette_bus),
      .i_dma_load          (dma_load),
      .i_dma_data          (dma_data),
      .i_flyback           (flyback),
      .i_sync_req          (sync_req),
      .o_sync_ack          (o_sync_ack),
      .o_r                 (o_r),
      .o_g                 (o_g),
      .o_b                 (o_b),
      .o_hsync             (o_hsync),
      .o_vsync             (o_vsync),
      .o_de                (o_de),
      .o_blank             (o_blank)
   );

   task automatic report_mismatch(input string msg);
      $display("FAIL %0t: %s", $time, msg);
      errors++;
   endtask

   //////////////////////////////////////////////////
   // Always-on checks

   a_blank_inv: assert property (@(posedge pclk) o_blank === ~o_de)
      else report_mismatch("o_blank is not the inverse of o_de");

   a_de_outside_hsync: assert property (@(posedge pclk) disable iff (reset)
      !(o_de && o_hsync))
      else report_mismatch("o_de high during o_hsync");

   //////////////////////////////////////////////////
   // Geometry monitor

   bit h_prev;
   bit v_prev;
   bit de_prev;
   int h_period;
   int h_high;
   int de_run;
   int de_lines;
   int frame_lines;
   int vs_lines;
   int vs_rises;

   always @(posedge pclk) begin
      if (reset || hs_busy) begin
         vs_rises = 0;
      end
      // Frame edges go first since an hsync rise shares the same sample
      if (o_vsync && !v_prev) begin
         vs_rises++;
         if (vs_rises >= 2) begin
            assert (frame_lines == 10) else report_mismatch("frame is not 10 lines");
            assert (de_lines == 6) else report_mismatch("frame has not 6 display lines");
            frames_checked <= frames_checked + 1;
         end
         frame_lines = 0;
         de_lines    = 0;
         vs_lines    = 0;
      end
      if (!o_vsync && v_prev && vs_rises >= 2) begin
         assert (vs_lines == 2) else report_mismatch("vsync not high for 2 lines");
      end
      // Line period and sync width
      if (o_hsync && !h_prev) begin
         if (vs_rises >= 2) begin
            assert (h_period == 24) else report_mismatch("line is not 24 cycles");
         end
         h_period = 1;
         h_high   = 1;
         frame_lines++;
         if (o_vsync) begin
            vs_lines++;
         end
      end else begin
         h_period++;
         if (o_hsync) begin
            h_high++;
         end
      end
      if (!o_hsync && h_prev && vs_rises >= 2) begin
         assert (h_high == 4) else report_mismatch("hsync not high for 4 cycles");
      end
      // Display runs
      if (o_de) begin
         de_run++;
      end else if (de_prev) begin
         if (vs_rises >= 2) begin
            assert (de_run == 16) else report_mismatch("de run is not 16 cycles");
         end
         de_lines++;
         de_run = 0;
      end
      h_prev  = o_hsync;
      v_prev  = o_vsync;
      de_prev = o_de;
   end

   //////////////////////////////////////////////////
   // Pixel reference model

   function automatic logic [7:0] model_index(input int bits, input int x, input int y);
      int          ppw;
      logic [31:0] w;
      logic [31:0] field;
      ppw   = 32 / bits;
      w     = words_m[y % 2][x / ppw];
      // Pixel 0 in the lowest bits
      field = w >> ((x % ppw) * bits);
      return 8'(field & ((32'd1 << bits) - 32'd1));
   endfunction

   function automatic logic [7:0] widen(input logic [3:0] c);
      return {c, c[0], c[0], c[0], c[0]};
   endfunction

   bit pix_armed;
   bit pv_prev;
   bit pde_prev;
   int row;
   int col;

   always @(posedge pclk) begin : pixel_check
      logic [7:0]  p;
      logic [11:0] e;
      logic [3:0]  r4;
      logic [3:0]  g4;
      logic [3:0]  b4;
      if (!pix_en) begin
         pix_armed = 1'b0;
      end else if (o_vsync && !pv_prev) begin
         pix_armed = 1'b1;
      end
      if (o_vsync) begin
         row = 0;
      end
      if (o_de) begin
         if (pix_armed) begin
            p  = model_index(cur_bits, col, row);
            e  = pal_m[p[3:0]];
            r4 = e[3:0];
            g4 = e[7:4];
            b4 = e[11:8];
            // 8bpp pixel bits replace the top of each channel
            if (cur_bits == 8) begin
               r4 = {p[4], e[2:0]};
               g4 = {p[6:5], e[5:4]};
               b4 = {p[7], e[10:8]};
            end
            assert (o_r == widen(r4) && o_g == widen(g4) && o_b == widen(b4))
               else report_mismatch($sformatf("pixel x %0d y %0d rgb %h %h %h", col, row,
                                              o_r, o_g, o_b));
            pixels_checked <= pixels_checked + 1;
         end
         col++;
      end else begin
         col = 0;
         if (pde_prev) begin
            row++;
         end
      end
      pv_prev  = o_vsync;
      pde_prev = o_de;
   end

   //////////////////////////////////////////////////
   // Stimulus tasks

   task automatic run_handshake();
      logic ack_before;
      bit   done;
      @(posedge pclk);
      ack_before = o_sync_ack;
      hs_busy  <= 1'b1;
      sync_req <= ~sync_req;
      // The ack must not move before any flyback
      repeat (16) begin
         @(posedge pclk);
         assert (o_sync_ack == ack_before) else report_mismatch("ack moved before flyback");
      end
      flyback <= 1'b1;
      repeat (4) begin
         @(posedge pclk);
         assert (o_sync_ack == ack_before) else report_mismatch("ack moved during flyback");
      end
      flyback <= 1'b0;
      done = 1'b0;
      for (int i = 0; i < 40 && !done; i++) begin
         @(posedge pclk);
         if (o_sync_ack == sync_req) begin
            done = 1'b1;
         end
      end
      if (!done) begin
         $display("Timeout: acknowledge never followed the request");
         timed_out = 1'b1;
      end
      hs_busy <= 1'b0;
   endtask

   task automatic load_banks(input int words_per_bank);
      for (int b = 0; b < 2; b++) begin
         for (int w = 0; w < words_per_bank; w++) begin
            @(posedge pclk);
            words_m[b][w] = $urandom;
            dma_load <= 1'b1;
            dma_data <= words_m[b][w];
         end
      end
      @(posedge pclk);
      dma_load <= 1'b0;
   endtask

   task automatic new_palette();
      @(posedge pclk);
      for (int i = 0; i < PAL_ENTRIES; i++) begin
         pal_m[i] = 12'($urandom);
         palette_bus[i*PAL_W +: PAL_W] <= pal_m[i];
      end
   endtask

   task automatic wait_frames(input int n);
      int start;
      start = frames_checked;
      for (int i = 0; i < 4000 && frames_checked - start < n; i++) begin
         @(posedge pclk);
      end
      if (frames_checked - start < n) begin
         $display("Timeout: geometry frames never arrived");
         timed_out = 1'b1;
      end
   endtask

   task automatic wait_pixels(input int n);
      int start;
      start = pixels_checked;
      for (int i = 0; i < 4000 && pixels_checked - start < n; i++) begin
         @(posedge pclk);
      end
      if (pixels_checked - start < n) begin
         $display("Timeout: display pixels never reached the checker");
         timed_out = 1'b1;
      end
   endtask

   task automatic run_content(input bpp_t depth, input int bits, input logic [7:0] m1);
      @(posedge pclk);
      pix_en   <= 1'b0;
      bpp      <= depth;
      words_m1 <= m1;
      new_palette();
      // Pixel checker is already disarmed here
      cur_bits = bits;
      run_handshake();
      if (!timed_out) begin
         load_banks(int'(m1) + 1);
         pix_en <= 1'b1;
         // Two full frames of 6 lines by 16 pixels
         wait_pixels(192);
      end
   endtask

   task automatic end_test(input string name, input int errs_before);
      tests_run++;
      if (errors != errs_before || timed_out) begin
         tests_failed++;
         $display("Test %s: FAIL", name);
      end else begin
         $display("Test %s: PASS", name);
      end
   endtask

   //////////////////////////////////////////////////
   // Main sequence

   initial begin
      int e0;
      void'($urandom(32'he814));
      h_res = 11'd16;
      h_sync = 11'd4;
      h_bp = 11'd2;
      h_fp = 11'd2;
      v_res = 11'd6;
      v_sync = 11'd2;
      v_bp = 11'd1;
      v_fp = 11'd1;
      bpp = BPP4;
      words_m1 = 8'd1;
      palette_bus = '0;
      dma_load = 1'b0;
      dma_data = '0;
      flyback = 1'b0;
      sync_req = 1'b0;
      hs_busy = 1'b1;
      cur_bits = 4;

      // Reset values during reset and shortly after
      e0 = errors;
      @(posedge pclk);
      for (int i = 0; i < 10; i++) begin
         @(posedge pclk);
         assert (o_sync_ack == 1'b0 && o_de == 1'b0)
            else report_mismatch("ack or de not low around reset");
      end
      end_test("reset", e0);

      e0 = errors;
      run_handshake();
      end_test("handshake", e0);

      if (!timed_out) begin
         e0 = errors;
         wait_frames(3);
         end_test("geometry", e0);
      end
      if (!timed_out) begin
         e0 = errors;
         run_content(BPP4, 4, 8'd1);
         end_test("content_4bpp", e0);
      end
      if (!timed_out) begin
         e0 = errors;
         run_content(BPP8, 8, 8'd3);
         end_test("content_8bpp", e0);
      end
      if (!timed_out) begin
         e0 = errors;
         run_content(BPP1, 1, 8'd0);
         end_test("content_1bpp", e0);
      end

      $display("Tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
      if (errors == 0 && tests_failed == 0 && !timed_out) begin
         $display("Simulation completed successfully");
      end else begin
         $display("Simulation failed");
      end
      $finish;
   end

endmodule

`default_nettype wire

// File: sim/tb_clock.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clock (
   output logic o_pclk,
   output logic o_reset
);

   // 10 ns pixel clock
   initial begin
      o_pclk = 1'b0;
      forever #5 o_pclk = ~o_pclk;
   end

   // Reset held for the first 4 rising edges
   initial begin
      o_reset = 1'b1;
      repeat (4) @(posedge o_pclk);
      o_reset <= 1'b0;
   end

endmodule

`default_nettype wire

// File: design/video_top.sv
`timescale 1ns/1ps
`default_nettype none

module video_top
   import vt_pkg::*;
(
   input  wire                          i_pclk,
   input  wire                          i_reset,
   input  wire  [COORD_W-1:0]           i_h_res,
   input  wire  [COORD_W-1:0]           i_h_fp,
   input  wire  [COORD_W-1:0]           i_h_sync,
   input  wire  [COORD_W-1:0]           i_h_bp,
   input  wire  [COORD_W-1:0]           i_v_res,
   input  wire  [COORD_W-1:0]           i_v_fp,
   input  wire  [COORD_W-1:0]           i_v_sync,
   input  wire  [COORD_W-1:0]           i_v_bp,
   input  bpp_t                         i_bpp,
   input  wire  [7:0]                   i_words_per_line_m1,
   input  wire  [PAL_ENTRIES*PAL_W-1:0] i_palette,
   input  wire                          i_dma_load,
   input  wire  [WORD_W-1:0]            i_dma_data,
   input  wire                          i_flyback,
   input  wire                          i_sync_req,
   output logic                         o_sync_ack,
   output logic [CHAN_W-1:0]            o_r,
   output logic [CHAN_W-1:0]            o_g,
   output logic [CHAN_W-1:0]            o_b,
   output logic                         o_hsync,
   output logic                         o_vsync,
   output logic                         o_de,
   output logic                         o_blank
);

   // Control
   logic                 vid_enable;
   logic                 frame_start;
   // Stage 0 timing
   logic                 hsync0;
   logic                 vsync0;
   logic                 de0;
   logic [COORD_W-1:0]   disp_x;
   logic [COORD_W-1:0]   disp_y;
   // Pixel path
   logic [LB_ADDR_W-1:0] rd_addr;
   logic [WORD_W-1:0]    rd_data;
   pix_index_t           index;

   frame_sync frame_sync_i (
      .i_pclk        (i_pclk),
      .i_reset       (i_reset),
      .i_sync_req    (i_sync_req),
      .i_flyback     (i_flyback),
      .o_sync_ack    (o_sync_ack),
      .o_vid_enable  (vid_enable),
      .o_frame_start (frame_start)
   );

   timing_gen timing_gen_i (
      .i_pclk       (i_pclk),
      .i_reset      (i_reset),
      .i_vid_enable (vid_enable),
      .i_h_res      (i_h_res),
      .i_h_fp       (i_h_fp),
      .i_h_sync     (i_h_sync),
      .i_h_bp       (i_h_bp),
      .i_v_res      (i_v_res),
      .i_v_fp       (i_v_fp),
      .i_v_sync     (i_v_sync),
      .i_v_bp       (i_v_bp),
      .o_hsync      (hsync0),
      .o_vsync      (vsync0),
      .o_de         (de0),
      .o_disp_x     (disp_x),
      .o_disp_y     (disp_y)
   );

   line_buffer line_buffer_i (
      .i_pclk              (i_pclk),
      .i_reset             (i_reset),
      .i_frame_start       (frame_start),
      .i_dma_load          (i_dma_load),
      .i_dma_data          (i_dma_data),
      .i_words_per_line_m1 (i_words_per_line_m1),
      .i_rd_addr           (rd_addr),
      .o_rd_data           (rd_data)
   );

   pixel_fetch pixel_fetch_i (
      .i_pclk    (i_pclk),
      .i_bpp     (i_bpp),
      .i_disp_x  (disp_x),
      .i_disp_y  (disp_y),
      .i_rd_data (rd_data),
      .o_rd_addr (rd_addr),
      .o_index   (index)
   );

   video_out video_out_i (
      .i_pclk    (i_pclk),
      .i_reset   (i_reset),
      .i_bpp     (i_bpp),
      .i_index   (index),
      .i_palette (i_palette),
      .i_hsync   (hsync0),
      .i_vsync   (vsync0),
      .i_de      (de0),
      .o_r       (o_r),
      .o_g       (o_g),
      .o_b       (o_b),
      .o_hsync   (o_hsync),
      .o_vsync   (o_vsync),
      .o_de      (o_de),
      .o_blank   (o_blank)
   );

endmodule

`default_nettype wire

// File: design/video_out.sv
`timescale 1ns/1ps
`default_nettype none

module video_out
   import vt_pkg::*;
(
   input  wire                         i_pclk,
   input  wire                         i_reset,
   input  bpp_t                        i_bpp,
   input  pix_index_t                  i_index,
   input  wire  [PAL_ENTRIES*PAL_W-1:0] i_palette,
   input  wire                         i_hsync,
   input  wire                         i_vsync,
   input  wire                         i_de,
   output logic [CHAN_W-1:0]           o_r,
   output logic [CHAN_W-1:0]           o_g,
   output logic [CHAN_W-1:0]           o_b,
   output logic                        o_hsync,
   output logic                        o_vsync,
   output logic                        o_de,
   output logic                        o_blank
);

   // 4 bits to 8 by repeating the low bit
   function automatic logic [CHAN_W-1:0] expand(input logic [3:0] c);
      expand = {c, {4{c[0]}}};
   endfunction

   //////////////////////////////////////////////////
   // Stage 2 to 3, palette lookup

   logic [PAL_W-1:0] pal_q;
   pix_index_t       index_q;
   logic [PAL_W-1:0] colour;

   always_ff @(posedge i_pclk) begin
      pal_q   <= i_palette[i_index[PAL_IDX_W-1:0] * PAL_W +: PAL_W];
      // Whole byte kept for 8bpp composition
      index_q <= i_index;
   end

   // 8bpp takes the top bit of each channel from the pixel itself
   // Blue from bit 7, green from bits 6:5, red from bit 4
   always_comb begin
      if (i_bpp == BPP8) begin
         colour = {index_q[7], pal_q[10:8],
                   index_q[6:5], pal_q[5:4],
                   index_q[4], pal_q[2:0]};
      end else begin
         colour = pal_q;
      end
   end

   //////////////////////////////////////////////////
   // Stage 3 to 4, output registers

   always_ff @(posedge i_pclk) begin
      o_r <= expand(colour[3:0]);
      o_g <= expand(colour[7:4]);
      o_b <= expand(colour[11:8]);
   end

   //////////////////////////////////////////////////
   // Sync delay

   // hsync, vsync, de per stage
   logic [2:0] sync_pipe [OUT_LATENCY];

   always_ff @(posedge i_pclk) begin
      if (i_reset) begin
         for (int i = 0; i < OUT_LATENCY; i++) begin
            sync_pipe[i] <= '0;
         end
      end else begin
         sync_pipe[0] <= {i_hsync, i_vsync, i_de};
         for (int i = 1; i < OUT_LATENCY; i++) begin
            sync_pipe[i] <= sync_pipe[i-1];
         end
      end
   end

   // Last stage lines up with the colour registers
   assign o_hsync = sync_pipe[OUT_LATENCY-1][2];
   assign o_vsync = sync_pipe[OUT_LATENCY-1][1];
   assign o_de    = sync_pipe[OUT_LATENCY-1][0];
   assign o_blank = ~o_de;

endmodule

`default_nettype wire

// File: design/pixel_fetch.sv
`timescale 1ns/1ps
`default_nettype none

module pixel_fetch
   import vt_pkg::*;
(
   input  wire                  i_pclk,
   input  bpp_t                 i_bpp,
   input  wire  [COORD_W-1:0]   i_disp_x,
   input  wire  [COORD_W-1:0]   i_disp_y,
   input  wire  [WORD_W-1:0]    i_rd_data,
   output logic [LB_ADDR_W-1:0] o_rd_addr,
   output pix_index_t           o_index
);

   //////////////////////////////////////////////////
   // Stage 0, buffer address

   // log2 of pixels per word, 5 at 1bpp down to 2 at 8bpp
   logic [2:0]         ppw_shift;
   logic [COORD_W-1:0] x_word;

   assign ppw_shift = 3'd5 - {1'b0, i_bpp};
   assign x_word    = i_disp_x >> ppw_shift;

   // Even lines read bank 0, odd lines bank 1
   assign o_rd_addr = {i_disp_y[0], x_word[LB_ADDR_W-2:0]};

   //////////////////////////////////////////////////
   // Stage 1, pixel position within the word

   // Enough x bits for the 32 pixels of a 1bpp word
   logic [4:0] x_sel;

   // Travels with the buffer read
   always_ff @(posedge i_pclk) begin
      x_sel <= i_disp_x[4:0];
   end

   //////////////////////////////////////////////////
   // Stage 1 to 2, index extract

   pix_index_t pix;

   // Pixel 0 sits in the lowest bits of the word
   always_comb begin
      case (i_bpp)
         BPP1: begin
            pix = {7'd0, i_rd_data[x_sel]};
         end
         BPP2: begin
            pix = {6'd0, i_rd_data[{x_sel[3:0], 1'b0} +: 2]};
         end
         BPP4: begin
            pix = {4'd0, i_rd_data[{x_sel[2:0], 2'b00} +: 4]};
         end
         default: begin
            // Full byte, the upper bits feed colour composition
            pix = i_rd_data[{x_sel[1:0], 3'b000} +: 8];
         end
      endcase
   end

   always_ff @(posedge i_pclk) begin
      o_index <= pix;
   end

endmodule

`default_nettype wire

// File: design/line_buffer.sv
`timescale 1ns/1ps
`default_nettype none

module line_buffer
   import vt_pkg::*;
(
   input  wire                  i_pclk,
   input  wire                  i_reset,
   input  wire                  i_frame_start,
   input  wire                  i_dma_load,
   input  wire  [WORD_W-1:0]    i_dma_data,
   input  wire  [7:0]           i_words_per_line_m1,
   input  wire  [LB_ADDR_W-1:0] i_rd_addr,
   output logic [WORD_W-1:0]    o_rd_data
);

   // Bank 0 holds even display lines, bank 1 odd ones
   logic [WORD_W-1:0] mem [2*LB_DEPTH];

   //////////////////////////////////////////////////
   // Write side

   logic [LB_ADDR_W-1:0] wr_ptr;
   logic                 wr_bank;
   logic [7:0]           wr_word;

   assign wr_bank = wr_ptr[LB_ADDR_W-1];
   assign wr_word = wr_ptr[LB_ADDR_W-2:0];

   always_ff @(posedge i_pclk) begin
      if (i_reset) begin
         wr_ptr <= '0;
      end else if (i_frame_start) begin
         // New frame fills bank 0 from word 0
         wr_ptr <= '0;
      end else if (i_dma_load) begin
         // Line complete, swap to the other bank
         if (wr_word == i_words_per_line_m1) begin
            wr_ptr <= {~wr_bank, 8'h00};
         end else begin
            wr_ptr <= wr_ptr + LB_ADDR_W'(1);
         end
      end
   end

   always_ff @(posedge i_pclk) begin
      if (i_dma_load) begin
         mem[wr_ptr] <= i_dma_data;
      end
   end

   //////////////////////////////////////////////////
   // Read side

   // One cycle read, stage 1 of the pixel pipe
   always_ff @(posedge i_pclk) begin
      o_rd_data <= mem[i_rd_addr];
   end

   // DMA words never land past the configured line length
   a_wr_in_line: assert property (@(posedge i_pclk) disable iff (i_reset)
      i_dma_load && !i_frame_start |-> wr_word <= i_words_per_line_m1);

endmodule

`default_nettype wire

// File: design/timing_gen.sv
`timescale 1ns/1ps
`default_nettype none

module timing_gen
   import vt_pkg::*;
(
   input  wire                i_pclk,
   input  wire                i_reset,
   input  wire                i_vid_enable,
   input  wire  [COORD_W-1:0] i_h_res,
   input  wire  [COORD_W-1:0] i_h_fp,
   input  wire  [COORD_W-1:0] i_h_sync,
   input  wire  [COORD_W-1:0] i_h_bp,
   input  wire  [COORD_W-1:0] i_v_res,
   input  wire  [COORD_W-1:0] i_v_fp,
   input  wire  [COORD_W-1:0] i_v_sync,
   input  wire  [COORD_W-1:0] i_v_bp,
   output logic               o_hsync,
   output logic               o_vsync,
   output logic               o_de,
   output logic [COORD_W-1:0] o_disp_x,
   output logic [COORD_W-1:0] o_disp_y
);

   //////////////////////////////////////////////////
   // Timing marks

   // Syncs sit at coordinate 0, display starts after sync and back porch
   // Sync off, display start and display end are first positions past each phase
   logic [COORD_W-1:0] h_sync_off, h_disp_start, h_disp_end, h_total;
   logic [COORD_W-1:0] v_sync_off, v_disp_start, v_disp_end, v_total;

   //////////////////////////////////////////////////
   // Counters

   logic [COORD_W-1:0] px;
   logic [COORD_W-1:0] py;
   logic [COORD_W-1:0] px_nxt;
   logic [COORD_W-1:0] py_nxt;
   logic               line_end;
   logic               h_vis_nxt;
   logic               v_vis_nxt;

   // Next position, flags are registered from it
   always_comb begin
      line_end = (px == h_total);
      px_nxt   = line_end ? '0 : px + COORD_W'(1);
      if (!line_end) begin
         py_nxt = py;
      end else if (py == v_total) begin
         py_nxt = '0;
      end else begin
         py_nxt = py + COORD_W'(1);
      end
      h_vis_nxt = (px_nxt >= h_disp_start) && (px_nxt < h_disp_end);
      v_vis_nxt = (py_nxt >= v_disp_start) && (py_nxt < v_disp_end);
   end

   always_ff @(posedge i_pclk) begin
      if (i_reset) begin
         h_sync_off   <= '0;
         h_disp_start <= '0;
         h_disp_end   <= '0;
         h_total      <= '0;
         v_sync_off   <= '0;
         v_disp_start <= '0;
         v_disp_end   <= '0;
         v_total      <= '0;
         px           <= '0;
         py           <= '0;
         o_hsync      <= 1'b0;
         o_vsync      <= 1'b0;
         o_de         <= 1'b0;
         o_disp_x     <= '0;
         o_disp_y     <= '0;
      end else if (!i_vid_enable) begin
         // Held, take the new timing
         h_sync_off   <= i_h_sync;
         h_disp_start <= i_h_sync + i_h_bp;
         h_disp_end   <= i_h_sync + i_h_bp + i_h_res;
         h_total      <= i_h_sync + i_h_bp + i_h_res + i_h_fp - COORD_W'(1);
         v_sync_off   <= i_v_sync;
         v_disp_start <= i_v_sync + i_v_bp;
         v_disp_end   <= i_v_sync + i_v_bp + i_v_res;
         v_total      <= i_v_sync + i_v_bp + i_v_res + i_v_fp - COORD_W'(1);
         // Park at pixel 0 of the first display line
         px           <= '0;
         py           <= i_v_sync + i_v_bp;
         o_hsync      <= 1'b1;
         o_vsync      <= 1'b0;
         o_de         <= 1'b0;
         o_disp_x     <= '0;
         o_disp_y     <= '0;
      end else begin
         px      <= px_nxt;
         py      <= py_nxt;
         o_hsync <= px_nxt < h_sync_off;
         o_vsync <= py_nxt < v_sync_off;
         o_de    <= h_vis_nxt && v_vis_nxt;
         // Logical x restarts at each display run
         if (h_vis_nxt && v_vis_nxt && o_de) begin
            o_disp_x <= o_disp_x + COORD_W'(1);
         end else begin
            o_disp_x <= '0;
         end
         // Logical line, only meaningful on display lines
         o_disp_y <= py_nxt - v_disp_start;
      end
   end

   // Display region never overlaps horizontal sync
   a_de_not_in_hsync: assert property (@(posedge i_pclk) disable iff (i_reset)
      !(o_de && o_hsync));

endmodule

`default_nettype wire

// File: design/frame_sync.sv
`timescale 1ns/1ps
`default_nettype none

module frame_sync
   import vt_pkg::*;
(
   input  wire  i_pclk,
   input  wire  i_reset,
   input  wire  i_sync_req,
   input  wire  i_flyback,
   output logic o_sync_ack,
   output logic o_vid_enable,
   output logic o_frame_start
);

   //////////////////////////////////////////////////
   // Input synchronisers

   logic [1:0] req_sync;
   // Two sync stages plus the previous value for edge detect
   logic [2:0] fb_sync;
   logic       req_pending;
   logic       fb_fall;

   always_ff @(posedge i_pclk) begin
      if (i_reset) begin
         req_sync <= '0;
         fb_sync  <= '0;
      end else begin
         req_sync <= {req_sync[0], i_sync_req};
         fb_sync  <= {fb_sync[1:0], i_flyback};
      end
   end

   // Toggle protocol, request differs from ack while one is open
   assign req_pending = req_sync[1] != o_sync_ack;
   // Flyback just ended
   assign fb_fall = fb_sync[2] & ~fb_sync[1];
   assign o_frame_start = fb_fall;

   //////////////////////////////////////////////////
   // Resync control

   logic              resync;
   logic [HOLD_W-1:0] hold_ctr;

   always_ff @(posedge i_pclk) begin
      if (i_reset) begin
         resync       <= 1'b0;
         hold_ctr     <= '0;
         o_vid_enable <= 1'b1;
         o_sync_ack   <= 1'b0;
      end else if (!resync) begin
         // New timing requested, stop the scan
         if (req_pending) begin
            resync       <= 1'b1;
            o_vid_enable <= 1'b0;
            hold_ctr     <= HOLD_W'(RESYNC_HOLD - 1);
         end
      end else if (hold_ctr != '0) begin
         // Let the timing generator pick up the new marks
         // A flyback edge seen here is skipped, the next frame is used
         hold_ctr <= hold_ctr - HOLD_W'(1);
      end else if (fb_fall) begin
         // Release the scan in step with the flyback and close the request
         resync       <= 1'b0;
         o_vid_enable <= 1'b1;
         o_sync_ack   <= ~o_sync_ack;
      end
   end

   // Ack only moves when the scan is released
   a_ack_on_release: assert property (@(posedge i_pclk) disable iff (i_reset)
      $changed(o_sync_ack) |-> $rose(o_vid_enable));

   // Held for the full reload time
   a_hold_min: assert property (@(posedge i_pclk) disable iff (i_reset)
      $fell(o_vid_enable) |-> (!o_vid_enable) [*RESYNC_HOLD]);

endmodule

`default_nettype wire

// File: design/vt_pkg.sv
`default_nettype none

package vt_pkg;

   //////////////////////////////////////////////////
   // Scan geometry

   // Pixel and line counters, and every timing field
   localparam int COORD_W = 11;

   //////////////////////////////////////////////////
   // Line buffer

   // DMA word and buffer word
   localparam int WORD_W = 32;
   // Words in one half of the buffer
   localparam int LB_DEPTH = 256;
   // Bank bit sits above the word index
   localparam int LB_ADDR_W = 9;

   //////////////////////////////////////////////////
   // Palette and output

   localparam int PAL_ENTRIES = 16;
   // Three 4-bit channels, red lowest
   localparam int PAL_W = 12;
   localparam int PAL_IDX_W = 4;
   localparam int CHAN_W = 8;

   //////////////////////////////////////////////////
   // Control and pipeline

   // Shortest time the scan is held while a new timing is taken
   localparam int RESYNC_HOLD = 3;
   localparam int HOLD_W = $clog2(RESYNC_HOLD);
   // Buffer read, index extract, palette register, output register
   localparam int OUT_LATENCY = 4;

   // Pixel depth, pixels per word is 32 >> value
   typedef enum logic [1:0] {
      BPP1 = 2'd0,
      BPP2 = 2'd1,
      BPP4 = 2'd2,
      BPP8 = 2'd3
   } bpp_t;

   // Low nibble indexes the palette
   // Upper bits only matter for 8bpp colour composition
   typedef logic [7:0] pix_index_t;

endpackage

`default_nettype wire
